// ==== Alu.sv ====
`timescale 1ns/100ps

module Alu (
    input  Types::AluOp i_operation,            // Selected operation
    input  logic [31:0] i_operandA,
    input  logic [31:0] i_operandB,
    output logic [31:0] o_result);

    always_comb begin
        unique case (i_operation)
            Types::AluOp_ADD:  o_result = i_operandA + i_operandB;
            Types::AluOp_SUB:  o_result = i_operandA - i_operandB;
            Types::AluOp_AND:  o_result = i_operandA & i_operandB;
            Types::AluOp_OR:   o_result = i_operandA | i_operandB;
            Types::AluOp_XOR:  o_result = i_operandA ^ i_operandB;
            Types::AluOp_SLL:  o_result = i_operandA << i_operandB[4:0]; // Shift amount is 5 bits
            Types::AluOp_SLT:  o_result = {31'd0, $signed(i_operandA) < $signed(i_operandB)};
            Types::AluOp_SLTU: o_result = {31'd0, i_operandA < i_operandB};
            default:           o_result = '0;  // Unknown and spare codes
        endcase
    end

endmodule

// ==== Datapath.sv ====
`timescale 1ns/100ps

module Datapath #(
    parameter logic [31:0] RESET_VECTOR = 32'h0000_0000
) (
    input  logic               i_clock,
    input  logic               i_reset,
    input  logic [31:0]        i_instData,      // Fetched word
    input  logic [31:0]        i_dataRdData,    // Data memory read word
    input  Types::AluOp        i_aluControl,
    input  Types::OperandASel  i_operandASel,
    input  Types::OperandBSel  i_operandBSel,
    input  logic               i_regWrEnable,
    input  Types::RegWrDataSel i_regWrDataSel,
    input  logic               i_memWrEnable,
    input  Types::PcNextSel    i_pcNextSel,
    output Types::Inst         o_inst,          // To the controller
    output logic               o_isEqual,
    output logic               o_isLess,
    output logic [31:0]        o_instAddr,
    output Types::DataReq      o_dataReq);

    logic [31:0] pc;
    logic [31:0] pcPlus4;
    logic [31:0] pcNext;
    logic [31:0] imm;
    logic [31:0] rs1Data;
    logic [31:0] rs2Data;
    logic [31:0] operandA;
    logic [31:0] operandB;
    logic [31:0] aluResult;
    logic [31:0] loadData;
    logic [31:0] wrData;                        // Writeback value

    assign o_inst     = i_instData;
    assign o_instAddr = pc;
    assign pcPlus4    = pc + 32'd4;

    // Branch compare, bit 13 marks BLTU and BGEU
    assign o_isEqual = rs1Data == rs2Data;
    assign o_isLess  = i_instData[13] ? (rs1Data < rs2Data) : ($signed(rs1Data) < $signed(rs2Data));

    always_comb begin
        case (i_operandASel)
            Types::OperandASel_Pc:   operandA = pc;      // AUIPC
            Types::OperandASel_Zero: operandA = '0;      // LUI
            default:                 operandA = rs1Data;
        endcase
        case (i_operandBSel)
            Types::OperandBSel_Imm:  operandB = imm;
            Types::OperandBSel_Four: operandB = 32'd4;
            default:                 operandB = rs2Data;
        endcase
        case (i_regWrDataSel)
            Types::RegWrDataSel_Mem: wrData = loadData;
            Types::RegWrDataSel_Pc4: wrData = pcPlus4;   // Link address
            default:                 wrData = aluResult;
        endcase
        case (i_pcNextSel)
            Types::PcNextSel_Offset:    pcNext = pc + imm;
            Types::PcNextSel_RegOffset: pcNext = (rs1Data + imm) & ~32'd1; // JALR clears bit 0
            default:                    pcNext = pcPlus4;
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (i_reset)
            pc <= RESET_VECTOR;
        else
            pc <= pcNext;                       // One instruction per edge
    end

    Alu u_Alu (.i_operation(i_aluControl), .i_operandA(operandA), .i_operandB(operandB),
        .o_result(aluResult));

    RegisterFile u_RegisterFile (.i_clock(i_clock), .i_reset(i_reset),
        .i_rdAddrA(i_instData[19:15]), .i_rdAddrB(i_instData[24:20]),
        .i_wrAddr(i_instData[11:7]), .i_wrData(wrData),
        .i_wrEnable(i_regWrEnable & ~i_reset),  // No writeback during reset
        .o_rdDataA(rs1Data), .o_rdDataB(rs2Data));

    ImmGenerator u_ImmGenerator (.i_inst(i_instData), .o_imm(imm));

    LoadStoreUnit u_LoadStoreUnit (.i_inst(i_instData), .i_addr(aluResult),
        .i_storeData(rs2Data),
        .i_memWrEnable(i_memWrEnable & ~i_reset), // Keep memory quiet while held in reset
        .i_rdWord(i_dataRdData), .o_dataReq(o_dataReq), .o_loadData(loadData));

endmodule

// ==== DatapathController.sv ====
`timescale 1ns/100ps

module DatapathController (
    input  Types::Inst         i_inst,          // Current instruction
    input  logic               i_isEqual,       // rs1 == rs2
    input  logic               i_isLess,        // rs1 < rs2, signedness from funct3
    output logic               o_memWrEnable,   // Store strobe
    output Types::PcNextSel    o_pcNextSel,     // Next PC source
    output Types::AluOp        o_aluControl,    // ALU operation
    output Types::OperandASel  o_operandASel,   // ALU operand A source
    output Types::OperandBSel  o_operandBSel,   // ALU operand B source
    output logic               o_regWrEnable,   // Destination register write
    output Types::RegWrDataSel o_regWrDataSel); // Writeback source

    localparam Types::OperandASel  asREG = Types::OperandASel_Reg;
    localparam Types::OperandASel  asPC  = Types::OperandASel_Pc;
    localparam Types::OperandASel  asV0  = Types::OperandASel_Zero;
    localparam Types::OperandBSel  bsREG = Types::OperandBSel_Reg;
    localparam Types::OperandBSel  bsIMM = Types::OperandBSel_Imm;
    localparam Types::RegWrDataSel wrALU = Types::RegWrDataSel_Alu;
    localparam Types::RegWrDataSel wrMEM = Types::RegWrDataSel_Mem;
    localparam Types::RegWrDataSel wrPC4 = Types::RegWrDataSel_Pc4;
    localparam Types::PcNextSel    pcPP4 = Types::PcNextSel_Plus4;
    localparam Types::PcNextSel    pcOFS = Types::PcNextSel_Offset;
    localparam Types::PcNextSel    pcIND = Types::PcNextSel_RegOffset;

    // Control word layout, opA, opB, wrSel, regWr, memWr, pcSel, aluOp
    localparam logic [14:0] DP_ADD   = {asREG, bsREG, wrALU, 2'b10, pcPP4, Types::AluOp_ADD};
    localparam logic [14:0] DP_SUB   = {asREG, bsREG, wrALU, 2'b10, pcPP4, Types::AluOp_SUB};
    localparam logic [14:0] DP_AND   = {asREG, bsREG, wrALU, 2'b10, pcPP4, Types::AluOp_AND};
    localparam logic [14:0] DP_OR    = {asREG, bsREG, wrALU, 2'b10, pcPP4, Types::AluOp_OR};
    localparam logic [14:0] DP_XOR   = {asREG, bsREG, wrALU, 2'b10, pcPP4, Types::AluOp_XOR};
    localparam logic [14:0] DP_SLL   = {asREG, bsREG, wrALU, 2'b10, pcPP4, Types::AluOp_SLL};
    localparam logic [14:0] DP_SLT   = {asREG, bsREG, wrALU, 2'b10, pcPP4, Types::AluOp_SLT};
    localparam logic [14:0] DP_SLTU  = {asREG, bsREG, wrALU, 2'b10, pcPP4, Types::AluOp_SLTU};
    localparam logic [14:0] DP_ADDI  = {asREG, bsIMM, wrALU, 2'b10, pcPP4, Types::AluOp_ADD};
    localparam logic [14:0] DP_ANDI  = {asREG, bsIMM, wrALU, 2'b10, pcPP4, Types::AluOp_AND};
    localparam logic [14:0] DP_ORI   = {asREG, bsIMM, wrALU, 2'b10, pcPP4, Types::AluOp_OR};
    localparam logic [14:0] DP_XORI  = {asREG, bsIMM, wrALU, 2'b10, pcPP4, Types::AluOp_XOR};
    localparam logic [14:0] DP_SLTI  = {asREG, bsIMM, wrALU, 2'b10, pcPP4, Types::AluOp_SLT};
    localparam logic [14:0] DP_SLTIU = {asREG, bsIMM, wrALU, 2'b10, pcPP4, Types::AluOp_SLTU};
    localparam logic [14:0] DP_LUI   = {asV0,  bsIMM, wrALU, 2'b10, pcPP4, Types::AluOp_ADD};
    localparam logic [14:0] DP_AUIPC = {asPC,  bsIMM, wrALU, 2'b10, pcPP4, Types::AluOp_ADD};
    localparam logic [14:0] DP_BRNCH = {asREG, bsREG, wrALU, 2'b00, pcOFS, Types::AluOp_Unknown};
    localparam logic [14:0] DP_JAL   = {asREG, bsREG, wrPC4, 2'b10, pcOFS, Types::AluOp_Unknown};
    localparam logic [14:0] DP_JALR  = {asREG, bsREG, wrPC4, 2'b10, pcIND, Types::AluOp_Unknown};
    localparam logic [14:0] DP_LOAD  = {asREG, bsIMM, wrMEM, 2'b10, pcPP4, Types::AluOp_ADD};
    localparam logic [14:0] DP_STORE = {asREG, bsIMM, wrALU, 2'b01, pcPP4, Types::AluOp_ADD};

    logic [14:0] dp;                            // Decoded control word
    logic        br;                            // Taken branch or jump

    assign o_aluControl   = Types::AluOp'(dp[4:0]);
    assign o_memWrEnable  = dp[7];
    assign o_regWrEnable  = dp[8];
    assign o_regWrDataSel = Types::RegWrDataSel'(dp[10:9]);
    assign o_operandBSel  = Types::OperandBSel'(dp[12:11]);
    assign o_operandASel  = Types::OperandASel'(dp[14:13]);
    assign o_pcNextSel    = br ? Types::PcNextSel'(dp[6:5]) : pcPP4; // Fall through unless taken

    always_comb begin
        unique casez ({i_inst[14:12], i_inst[6:0], i_isEqual, i_isLess})
            {3'b000, Types::OpCode_Branch, 2'b1?}: br = 1'b1; // BEQ
            {3'b001, Types::OpCode_Branch, 2'b0?}: br = 1'b1; // BNE
            {3'b100, Types::OpCode_Branch, 2'b?1}: br = 1'b1; // BLT
            {3'b101, Types::OpCode_Branch, 2'b?0}: br = 1'b1; // BGE
            {3'b110, Types::OpCode_Branch, 2'b?1}: br = 1'b1; // BLTU
            {3'b111, Types::OpCode_Branch, 2'b?0}: br = 1'b1; // BGEU
            {3'b???, Types::OpCode_JAL,    2'b??}: br = 1'b1;
            {3'b000, Types::OpCode_JALR,   2'b??}: br = 1'b1;
            default:                               br = 1'b0;
        endcase
    end

    always_comb begin
        unique casez ({i_inst[31:25], i_inst[14:12], i_inst[6:0]})
            {10'b0000000_000, Types::OpCode_Op}:     dp = DP_ADD;
            {10'b0100000_000, Types::OpCode_Op}:     dp = DP_SUB;
            {10'b0000000_111, Types::OpCode_Op}:     dp = DP_AND;
            {10'b0000000_110, Types::OpCode_Op}:     dp = DP_OR;
            {10'b0000000_100, Types::OpCode_Op}:     dp = DP_XOR;
            {10'b0000000_001, Types::OpCode_Op}:     dp = DP_SLL;
            {10'b0000000_010, Types::OpCode_Op}:     dp = DP_SLT;
            {10'b0000000_011, Types::OpCode_Op}:     dp = DP_SLTU;
            {10'b???????_000, Types::OpCode_OpIMM}:  dp = DP_ADDI;
            {10'b???????_111, Types::OpCode_OpIMM}:  dp = DP_ANDI;
            {10'b???????_110, Types::OpCode_OpIMM}:  dp = DP_ORI;
            {10'b???????_100, Types::OpCode_OpIMM}:  dp = DP_XORI;
            {10'b???????_010, Types::OpCode_OpIMM}:  dp = DP_SLTI;
            {10'b???????_011, Types::OpCode_OpIMM}:  dp = DP_SLTIU;
            {10'b???????_???, Types::OpCode_LUI}:    dp = DP_LUI;
            {10'b???????_???, Types::OpCode_AUIPC}:  dp = DP_AUIPC;
            {10'b???????_???, Types::OpCode_Branch}: dp = DP_BRNCH; // Condition decided by br
            {10'b???????_???, Types::OpCode_JAL}:    dp = DP_JAL;
            {10'b???????_000, Types::OpCode_JALR}:   dp = DP_JALR;
            {10'b???????_000, Types::OpCode_Load}:   dp = DP_LOAD;  // LB
            {10'b???????_001, Types::OpCode_Load}:   dp = DP_LOAD;  // LH
            {10'b???????_010, Types::OpCode_Load}:   dp = DP_LOAD;  // LW
            {10'b???????_000, Types::OpCode_Store}:  dp = DP_STORE; // SB
            {10'b???????_001, Types::OpCode_Store}:  dp = DP_STORE; // SH
            {10'b???????_010, Types::OpCode_Store}:  dp = DP_STORE; // SW
            default:                                 dp = '0;       // Unsupported, acts as a no-op
        endcase
    end

endmodule

// ==== ImmGenerator.sv ====
`timescale 1ns/100ps

module ImmGenerator (
    input  Types::Inst  i_inst,
    output logic [31:0] o_imm);                 // Sign-extended immediate

    always_comb begin
        case (i_inst[6:0])
            Types::OpCode_OpIMM,
            Types::OpCode_JALR,
            Types::OpCode_Load:   o_imm = {{20{i_inst[31]}}, i_inst[31:20]}; // I type
            Types::OpCode_Store:  o_imm = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
            Types::OpCode_Branch: o_imm = {{19{i_inst[31]}}, i_inst[31], i_inst[7],
                                           i_inst[30:25], i_inst[11:8], 1'b0};
            Types::OpCode_LUI,
            Types::OpCode_AUIPC:  o_imm = {i_inst[31:12], 12'd0};            // U type
            Types::OpCode_JAL:    o_imm = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12],
                                           i_inst[20], i_inst[30:21], 1'b0};
            default:              o_imm = '0;  // R type and unknown
        endcase
    end

endmodule

// ==== LoadStoreUnit.sv ====
`timescale 1ns/100ps

module LoadStoreUnit (
    input  Types::Inst    i_inst,               // funct3 gives the access size
    input  logic [31:0]   i_addr,               // Byte address from the ALU
    input  logic [31:0]   i_storeData,          // rs2
    input  logic          i_memWrEnable,
    input  logic [31:0]   i_rdWord,             // Full word from data memory
    output Types::DataReq o_dataReq,
    output logic [31:0]   o_loadData);          // Extended load result

    logic [1:0]  lane;
    logic [3:0]  byteEnable;                    // Lanes touched by the access
    logic [31:0] laneWord;                      // Read word with the addressed byte at bit 0

    assign lane     = i_addr[1:0];
    assign laneWord = i_rdWord >> {lane, 3'b000};

    assign o_dataReq.addr       = {i_addr[31:2], 2'b00};
    assign o_dataReq.wrData     = i_storeData << {lane, 3'b000}; // Move into the addressed lane
    assign o_dataReq.byteEnable = byteEnable;
    assign o_dataReq.wrEnable   = i_memWrEnable;

    always_comb begin
        case (i_inst[14:12])
            3'b000: begin                       // Byte
                byteEnable = 4'b0001 << lane;
                o_loadData = {{24{laneWord[7]}}, laneWord[7:0]};
            end
            3'b001: begin                       // Halfword, lane 0 or 2
                byteEnable = 4'b0011 << lane;
                o_loadData = {{16{laneWord[15]}}, laneWord[15:0]};
            end
            default: begin
                byteEnable = 4'b1111;
                o_loadData = i_rdWord;
            end
        endcase
    end

endmodule

// ==== ProcessorCore.sv ====
`timescale 1ns/100ps

module ProcessorCore #(
    parameter logic [31:0] RESET_VECTOR = 32'h0000_0000
) (
    input  logic          i_clock,
    input  logic          i_reset,
    input  logic [31:0]   i_instData,           // Instruction memory read, same cycle
    input  logic [31:0]   i_dataRdData,         // Data memory read, same cycle
    output logic [31:0]   o_instAddr,
    output Types::DataReq o_dataReq);

    Types::Inst         inst;
    logic               isEqual;
    logic               isLess;
    Types::AluOp        aluControl;
    Types::OperandASel  operandASel;
    Types::OperandBSel  operandBSel;
    logic               regWrEnable;
    Types::RegWrDataSel regWrDataSel;
    logic               memWrEnable;
    Types::PcNextSel    pcNextSel;

    DatapathController u_DatapathController (
        .i_inst        (inst),
        .i_isEqual     (isEqual),
        .i_isLess      (isLess),
        .o_memWrEnable (memWrEnable),
        .o_pcNextSel   (pcNextSel),
        .o_aluControl  (aluControl),
        .o_operandASel (operandASel),
        .o_operandBSel (operandBSel),
        .o_regWrEnable (regWrEnable),
        .o_regWrDataSel(regWrDataSel));

    Datapath #(.RESET_VECTOR(RESET_VECTOR)) u_Datapath (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_instData    (i_instData),
        .i_dataRdData  (i_dataRdData),
        .i_aluControl  (aluControl),
        .i_operandASel (operandASel),
        .i_operandBSel (operandBSel),
        .i_regWrEnable (regWrEnable),
        .i_regWrDataSel(regWrDataSel),
        .i_memWrEnable (memWrEnable),
        .i_pcNextSel   (pcNextSel),
        .o_inst        (inst),
        .o_isEqual     (isEqual),
        .o_isLess      (isLess),
        .o_instAddr    (o_instAddr),
        .o_dataReq     (o_dataReq));

endmodule

// ==== RegisterFile.sv ====
`timescale 1ns/100ps

module RegisterFile (
    input  logic        i_clock,
    input  logic        i_reset,
    input  logic [4:0]  i_rdAddrA,              // rs1
    input  logic [4:0]  i_rdAddrB,              // rs2
    input  logic [4:0]  i_wrAddr,               // rd
    input  logic [31:0] i_wrData,
    input  logic        i_wrEnable,
    output logic [31:0] o_rdDataA,
    output logic [31:0] o_rdDataB);

    logic [31:0] regs [1:31];                   // No storage behind x0

    assign o_rdDataA = (i_rdAddrA == 5'd0) ? 32'd0 : regs[i_rdAddrA];
    assign o_rdDataB = (i_rdAddrB == 5'd0) ? 32'd0 : regs[i_rdAddrB];

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (i_wrEnable && i_wrAddr != 5'd0) begin
            regs[i_wrAddr] <= i_wrData;         // Writes to x0 dropped
        end
    end

endmodule

// ==== TbPrograms.svh ====
function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                     input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, Types::OpCode_Op};
endfunction

function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                     input logic [2:0] f3, input logic [4:0] rd,
                                     input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2, rs1,
                                     input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], Types::OpCode_Store};
endfunction

function automatic logic [31:0] encB(input logic [12:0] off, input logic [4:0] rs2, rs1,
                                     input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], Types::OpCode_Branch};
endfunction

function automatic logic [31:0] encJ(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, Types::OpCode_JAL};
endfunction

task automatic startProgram();
    for (int i = 0; i < 256; i++) begin
        imem[i]       = 32'd0;                  // Unknown encoding, falls through
        expNext[i]    = RESET_VECTOR + 32'(i) * 4 + 4;
        expStValid[i] = 1'b0;
        expMem[i]     = fillWord(i);            // Matches the reset fill of the data array
    end
    for (int r = 0; r < 32; r++)
        regVal[r] = 32'd0;
    asmPc  = RESET_VECTOR;
    stAddr = 32'd0;
endtask

task automatic emit(input logic [31:0] inst, input logic [31:0] nextPc);
    imem[slot(asmPc)]    = inst;
    expNext[slot(asmPc)] = nextPc;              // Fetch address expected after this one
    asmPc                = asmPc + 4;
endtask

task automatic setReg(input logic [4:0] rd, input logic [31:0] value);
    if (rd != 5'd0)
        regVal[rd] = value;                     // Shadow copy of the register file
endtask

task automatic li(input logic [4:0] rd, input logic [31:0] value);
    logic [31:0] hi;
    hi = value + 32'h800;                       // Rounds for the sign of the ADDI part
    emit({hi[31:12], rd, Types::OpCode_LUI}, asmPc + 4);
    emit(encI(value[11:0], rd, 3'd0, rd, Types::OpCode_OpIMM), asmPc + 4);
    setReg(rd, value);
endtask

task automatic storeReg(input logic [4:0] rs2, input logic [31:0] addr, input logic [2:0] f3);
    logic [7:0] s;
    logic [3:0] be;
    s  = slot(asmPc);
    be = (f3 == 3'd0) ? 4'b0001 : (f3 == 3'd1) ? 4'b0011 : 4'b1111;
    be = be << addr[1:0];                       // Lane rule
    expStValid[s] = 1'b1;
    expStAddr[s]  = {addr[31:2], 2'b00};
    expStBe[s]    = be;
    expStData[s]  = regVal[rs2] << {addr[1:0], 3'b000};
    for (int b = 0; b < 4; b++)
        if (be[b])
            expMem[addr[9:2]][8*b +: 8] = expStData[s][8*b +: 8];
    emit(encS(addr[11:0], rs2, 5'd0, f3), asmPc + 4);
endtask

task automatic saveResult(input logic [4:0] rs2);
    storeReg(rs2, stAddr, 3'd2);                // SW into the next result slot
    stAddr = stAddr + 4;
endtask

task automatic loadReg(input logic [4:0] rd, input logic [31:0] addr, input logic [2:0] f3);
    logic [31:0] w;
    w = expMem[addr[9:2]] >> {addr[1:0], 3'b000};
    if (f3 == 3'd0)
        w = {{24{w[7]}}, w[7:0]};
    else if (f3 == 3'd1)
        w = {{16{w[15]}}, w[15:0]};
    emit(encI(addr[11:0], 5'd0, f3, rd, Types::OpCode_Load), asmPc + 4);
    setReg(rd, w);
endtask

task automatic halt();
    haltPc = asmPc;
    emit(encJ(21'd0, 5'd0), asmPc);             // Jump to self
endtask

task automatic buildArith();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] immX;
    logic [2:0]  rF3 [8] = '{3'd0, 3'd0, 3'd7, 3'd6, 3'd4, 3'd1, 3'd2, 3'd3};
    logic [2:0]  iF3 [6] = '{3'd0, 3'd7, 3'd6, 3'd4, 3'd2, 3'd3};
    startProgram();
    for (int k = 0; k < 8; k++) begin
        a = $random(seed);
        b = $random(seed);
        li(5'd1, a);
        li(5'd2, b);
        emit(encR((k == 1) ? 7'b0100000 : 7'b0, 5'd2, 5'd1, rF3[k], 5'd3), asmPc + 4);
        setReg(5'd3, refAlu(rF3[k], k == 1, a, b));
        saveResult(5'd3);
    end
    for (int k = 0; k < 6; k++) begin
        a    = $random(seed);
        immX = $random(seed);
        immX = {{20{immX[11]}}, immX[11:0]};    // Sign-extended 12-bit immediate
        li(5'd1, a);
        emit(encI(immX[11:0], 5'd1, iF3[k], 5'd3, Types::OpCode_OpIMM), asmPc + 4);
        setReg(5'd3, refAlu(iF3[k], 1'b0, a, immX));
        saveResult(5'd3);
    end
    halt();
endtask

task automatic buildUpper();
    logic [31:0] u;
    startProgram();
    for (int k = 0; k < 3; k++) begin
        u = $random(seed);
        emit({u[31:12], 5'd3, Types::OpCode_LUI}, asmPc + 4);
        setReg(5'd3, {u[31:12], 12'd0});
        saveResult(5'd3);
        setReg(5'd3, asmPc + {u[31:12], 12'd0}); // PC of the AUIPC itself
        emit({u[31:12], 5'd3, Types::OpCode_AUIPC}, asmPc + 4);
        saveResult(5'd3);
    end
    halt();
endtask

task automatic buildBranch();
    logic [31:0] pa [5] = '{32'd7, 32'hffff_fffd, 32'd7, 32'd3, 32'd7};
    logic [31:0] pb [5] = '{32'd7, 32'd7, 32'hffff_fffd, 32'd7, 32'd3};
    logic [2:0]  bF3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    startProgram();
    for (int p = 0; p < 5; p++) begin           // Equal, less and greater both ways
        li(5'd1, pa[p]);
        li(5'd2, pb[p]);
        for (int k = 0; k < 6; k++) begin
            emit(encB(13'd8, 5'd2, 5'd1, bF3[k]),
                 branchTaken(bF3[k], pa[p], pb[p]) ? asmPc + 8 : asmPc + 4);
            emit(encI(12'd0, 5'd0, 3'd0, 5'd0, Types::OpCode_OpIMM), asmPc + 4); // NOP slot
        end
    end
    halt();
endtask

task automatic buildJump();
    logic [31:0] jalrPc;
    startProgram();
    setReg(5'd5, asmPc + 4);                    // JAL link
    emit(encJ(21'd8, 5'd5), asmPc + 8);
    emit(encI(12'd0, 5'd0, 3'd0, 5'd0, Types::OpCode_OpIMM), asmPc + 4);
    saveResult(5'd5);
    jalrPc = asmPc + 8;
    li(5'd6, jalrPc + 9);                       // Odd target, bit 0 gets cleared
    setReg(5'd7, jalrPc + 4);
    emit(encI(12'd0, 5'd6, 3'd0, 5'd7, Types::OpCode_JALR), jalrPc + 8);
    emit(encI(12'd0, 5'd0, 3'd0, 5'd0, Types::OpCode_OpIMM), asmPc + 4);
    saveResult(5'd7);
    halt();
endtask

task automatic buildMemory();
    startProgram();
    for (int lane = 0; lane < 4; lane++) begin
        li(5'd1, $random(seed));
        storeReg(5'd1, 32'h100 + 32'(lane), 3'd0); // SB
        loadReg(5'd4, 32'h100 + 32'(lane), 3'd0);  // LB
        saveResult(5'd4);
    end
    for (int lane = 0; lane < 4; lane += 2) begin
        li(5'd1, $random(seed));
        storeReg(5'd1, 32'h104 + 32'(lane), 3'd1); // SH
        loadReg(5'd4, 32'h104 + 32'(lane), 3'd1);  // LH
        saveResult(5'd4);
    end
    halt();
endtask

// ==== Testbench.sv ====
`timescale 1ns/100ps

module Testbench;

    localparam logic [31:0] RESET_VECTOR = 32'h0000_0400;
    localparam int          RUN_TIMEOUT  = 400;   // Cycles allowed per program
    localparam int          SETTLE_TIME  = 10;    // Quarter clock period

    logic          i_clock;
    logic          i_reset;
    logic [31:0]   i_instData;
    logic [31:0]   i_dataRdData;
    logic [31:0]   o_instAddr;
    Types::DataReq o_dataReq;

    logic [31:0] imem [256];                      // Word addressed from RESET_VECTOR
    logic [31:0] dmem [256];                      // Word addressed from zero
    logic [31:0] expMem [256];
    logic [31:0] expNext [256];
    logic        expStValid [256];
    logic [31:0] expStAddr [256];
    logic [31:0] expStData [256];
    logic [3:0]  expStBe [256];
    logic [31:0] regVal [32];
    logic [31:0] asmPc;
    logic [31:0] haltPc;
    logic [31:0] stAddr;
    int          seed;
    int          errorCount;
    int          failCount;
    string       names [6] = '{"reset", "arith", "upper", "branch", "jump", "memory"};

    ProcessorCore #(.RESET_VECTOR(RESET_VECTOR)) u_ProcessorCore (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_instData  (i_instData),
        .i_dataRdData(i_dataRdData),
        .o_instAddr  (o_instAddr),
        .o_dataReq   (o_dataReq));

    function automatic logic [7:0] slot(input logic [31:0] pc);
        return 8'((pc - RESET_VECTOR) >> 2);
    endfunction

    function automatic logic [31:0] fillWord(input int i);
        return (32'(i) << 2) * 32'h9e37_79b9 ^ 32'h5a5a_c3c3; // Every address bit matters
    endfunction

    // RV32I result by funct3, alt picks SUB
    function automatic logic [31:0] refAlu(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'd0, $signed(a) < $signed(b)};
            3'd3:    return {31'd0, a < b};
            3'd4:    return a ^ b;
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic bit branchTaken(input logic [2:0] f3, input logic [31:0] a, b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    `include "TbPrograms.svh"

    initial begin
        i_clock = 1'b0;
        forever #20 i_clock = ~i_clock;
    end

    assign i_instData   = imem[slot(o_instAddr)];  // Both memories answer in the same cycle
    assign i_dataRdData = dmem[o_dataReq.addr[9:2]];

    always @(posedge i_clock) begin
        if (i_reset) begin
            for (int i = 0; i < 256; i++)
                dmem[i] <= fillWord(i);
        end else if (o_dataReq.wrEnable) begin
            for (int b = 0; b < 4; b++)
                if (o_dataReq.byteEnable[b])
                    dmem[o_dataReq.addr[9:2]][8*b +: 8] <= o_dataReq.wrData[8*b +: 8];
        end
    end

    task automatic mismatch(input string name, input logic [31:0] expected, actual);
        errorCount++;
        $display("MISMATCH %s expected %h actual %h", name, expected, actual);
    endtask

    task automatic failure(input string text);
        errorCount++;
        $display("ERROR %s", text);
    endtask

    task automatic checkStore(input string name, input logic [31:0] pc);
        logic [7:0] s;
        s = slot(pc);
        assert (o_dataReq.wrEnable == expStValid[s]) else
            mismatch({name, " store enable"}, 32'(expStValid[s]), 32'(o_dataReq.wrEnable));
        if (expStValid[s]) begin
            assert (o_dataReq.addr == expStAddr[s]) else
                mismatch({name, " store address"}, expStAddr[s], o_dataReq.addr);
            assert (o_dataReq.wrData == expStData[s]) else
                mismatch({name, " store data"}, expStData[s], o_dataReq.wrData);
            assert (o_dataReq.byteEnable == expStBe[s]) else
                mismatch({name, " byte enable"}, {28'd0, expStBe[s]},
                         {28'd0, o_dataReq.byteEnable});
        end
    endtask

    task automatic runProgram(input int id);
        int          startErrors;
        int          cycles;
        logic [31:0] prevPc;
        startErrors = errorCount;
        i_reset     = 1'b1;                       // Load the program while held in reset
        case (id)
            1:       buildArith();
            2:       buildUpper();
            3:       buildBranch();
            4:       buildJump();
            5:       buildMemory();
            default: begin
                startProgram();
                storeReg(5'd0, 32'h200, 3'd2);    // SW under the reset PC, held off by reset
                halt();
            end
        endcase
        for (int c = 0; c < 3; c++) begin
            @(negedge i_clock);
            assert (o_instAddr == RESET_VECTOR) else
                mismatch({names[id], " reset pc"}, RESET_VECTOR, o_instAddr);
            assert (!o_dataReq.wrEnable) else
                failure({names[id], " data write enabled during reset"});
        end
        i_reset = 1'b0;
        #(SETTLE_TIME);                           // Mid-cycle, core now out of reset
        prevPc  = o_instAddr;
        assert (prevPc == RESET_VECTOR) else
            mismatch({names[id], " first fetch"}, RESET_VECTOR, prevPc);
        cycles = 0;
        while (prevPc != haltPc && cycles < RUN_TIMEOUT) begin
            checkStore(names[id], prevPc);
            @(negedge i_clock);
            cycles++;
            assert (o_instAddr == expNext[slot(prevPc)]) else
                mismatch({names[id], " next pc"}, expNext[slot(prevPc)], o_instAddr);
            prevPc = o_instAddr;
        end
        assert (prevPc == haltPc) else
            failure({names[id], " program never reached its final jump"});
        for (int i = 0; i < 256; i++)
            assert (dmem[i] == expMem[i]) else
                mismatch($sformatf("%s memory word %0d", names[id], i), expMem[i], dmem[i]);
        if (errorCount != startErrors)
            failCount++;
        $display("test %-8s %s", names[id], (errorCount == startErrors) ? "ok" : "FAILED");
    endtask

    initial begin
        seed       = 32'h6e31_e214;
        i_reset    = 1'b1;
        errorCount = 0;
        failCount  = 0;
        for (int t = 0; t < 6; t++)
            runProgram(t);
        $display("tests 6, passed %0d, failed %0d, errors %0d", 6 - failCount, failCount,
                 errorCount);
        if (errorCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== Types.sv ====
package Types;

    typedef logic [31:0] Inst;                  // Raw instruction word, fields taken by bit slice

    typedef enum logic [6:0] {
        OpCode_Op     = 7'b0110011,             // Register-register ALU
        OpCode_OpIMM  = 7'b0010011,             // Register-immediate ALU
        OpCode_AUIPC  = 7'b0010111,
        OpCode_LUI    = 7'b0110111,
        OpCode_Branch = 7'b1100011,             // Conditional branches
        OpCode_JAL    = 7'b1101111,
        OpCode_JALR   = 7'b1100111,
        OpCode_Load   = 7'b0000011,
        OpCode_Store  = 7'b0100011
    } OpCode;

    typedef enum logic [4:0] {
        AluOp_ADD,                              // Zero code, also the idle control word
        AluOp_SUB,
        AluOp_AND,
        AluOp_OR,
        AluOp_XOR,
        AluOp_SLL,
        AluOp_SLT,
        AluOp_SLTU,
        AluOp_Unknown                           // Result forced to zero
    } AluOp;

    typedef enum logic [1:0] {OperandASel_Reg, OperandASel_Pc, OperandASel_Zero} OperandASel;
    typedef enum logic [1:0] {OperandBSel_Reg, OperandBSel_Imm, OperandBSel_Four} OperandBSel;
    typedef enum logic [1:0] {RegWrDataSel_Alu, RegWrDataSel_Mem, RegWrDataSel_Pc4} RegWrDataSel;

    // Next PC source, register plus offset is the JALR target
    typedef enum logic [1:0] {PcNextSel_Plus4, PcNextSel_Offset, PcNextSel_RegOffset} PcNextSel;

    typedef struct packed {
        logic [31:0] addr;                      // Word aligned
        logic [31:0] wrData;                    // Already shifted into its byte lanes
        logic [3:0]  byteEnable;                // One bit per byte lane
        logic        wrEnable;                  // Write strobe, sampled on the rising edge
    } DataReq;

endpackage

// ==== files.f ====
+incdir+.
Types.sv
Alu.sv
RegisterFile.sv
ImmGenerator.sv
LoadStoreUnit.sv
DatapathController.sv
Datapath.sv
ProcessorCore.sv
Testbench.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module Testbench -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/simv)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "sim passed"; then
    exit 0
fi
exit 1
